//--- camera_top.f
logic/camera_pkg.sv
logic/frame_crop.sv
logic/bayer_metering.sv
logic/image_buffer.sv
logic/camera_registers.sv
logic/camera_top.sv
tb/camera_assertions.sv
tb/camera_tb.sv

//--- Bender.yml
package:
  name: camera_top

# RTL first, package before its users
sources:
  - target: rtl
    files:
      - logic/camera_pkg.sv
      - logic/frame_crop.sv
      - logic/bayer_metering.sv
      - logic/image_buffer.sv
      - logic/camera_registers.sv
      - logic/camera_top.sv

  # testbench, bound assertions before the top module
  - target: test
    files:
      - tb/camera_assertions.sv
      - tb/camera_tb.sv

//--- tb/camera_tb.sv
/*
 * Testbench for the camera front end: clock and reset, Bayer
 * frame generator, Wishbone read and write tasks, compare tasks,
 * directed tests for crop, capture and metering, and a timeout
 */
`timescale 1ns/1ns
`default_nettype none

module camera_tb;

    // frame geometry and run limit
    localparam int FRAME_COLS = 40;
    localparam int FRAME_ROWS = 30;
    localparam int LINE_BLANK = 8;
    localparam int FRAME_BLANK = 20;
    localparam int TIMEOUT_CYCLES = 20000;

    logic        mipi_byte_clock = 1'b0;
    logic        mipi_byte_reset_n;
    logic [9:0]  bayer_data;
    logic        line_valid;
    logic        frame_valid;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [11:0] wb_adr;
    logic [31:0] wb_dat;
    wire  [31:0] wb_dat_o;
    wire         wb_ack_o;
    int          cycle_count = 0;
    int          seed_first;
    int          seed_second;
    int          seed_third;
    logic [31:0] status_done;

    camera_top dut (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_data_i(bayer_data),
        .line_valid_i(line_valid),
        .frame_valid_i(frame_valid),
        .wb_cyc_i(wb_cyc),
        .wb_stb_i(wb_stb),
        .wb_we_i(wb_we),
        .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat),
        .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o)
    );

    always #50 mipi_byte_clock = ~mipi_byte_clock;

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    always @(posedge mipi_byte_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_metering(input camera_pkg::metering_t actual,
                                  input camera_pkg::metering_t expected, input string what);
        if (actual.word !== expected.word) begin
            $display("ERR %0t ns: %s is r=%0d g=%0d b=%0d, expected r=%0d g=%0d b=%0d",
                     $time, what, actual.fields.red, actual.fields.green, actual.fields.blue,
                     expected.fields.red, expected.fields.green, expected.fields.blue);
            abort_run();
        end
    endtask

    // classic cycle, ack seen on the second edge
    task automatic wb_access(input logic write, input logic [11:0] addr,
                             input logic [31:0] data, output logic [31:0] read_data);
        @(posedge mipi_byte_clock);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= write;
        wb_adr <= addr;
        wb_dat <= data;
        @(posedge mipi_byte_clock);
        @(posedge mipi_byte_clock);
        if (!wb_ack_o) begin
            $display("Wishbone ack missing in the second cycle of the access to %h", addr);
            abort_run();
        end
        read_data = wb_dat_o;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused_data;
        wb_access(1'b1, addr, data, unused_data);
    endtask

    task automatic wb_read(input logic [11:0] addr, output logic [31:0] data);
        wb_access(1'b0, addr, 32'd0, data);
    endtask

    function automatic logic [9:0] pixel_value(input int seed, input int col, input int row);
        return (seed + 7 * col + 13 * row) % 1024;
    endfunction

    task automatic send_frame(input int seed);
        int row;
        int col;
        @(posedge mipi_byte_clock);
        frame_valid <= 1'b1;
        repeat (FRAME_BLANK) @(posedge mipi_byte_clock);
        for (row = 0; row < FRAME_ROWS; row++) begin
            for (col = 0; col < FRAME_COLS; col++) begin
                line_valid <= 1'b1;
                bayer_data <= pixel_value(seed, col, row);
                @(posedge mipi_byte_clock);
            end
            line_valid <= 1'b0;
            repeat ((row == FRAME_ROWS - 1) ? FRAME_BLANK : LINE_BLANK) @(posedge mipi_byte_clock);
        end
        frame_valid <= 1'b0;
        repeat (FRAME_BLANK) @(posedge mipi_byte_clock);
    endtask

    // RGGB parity inside the window, count divide then drop 2 bits
    function automatic camera_pkg::metering_t expected_metering(input int seed, input int x0,
                                                                input int y0);
        camera_pkg::metering_t result;
        int red_sum;
        int green_sum;
        int blue_sum;
        int r;
        int c;
        red_sum = 0;
        green_sum = 0;
        blue_sum = 0;
        for (r = 0; r < camera_pkg::CROP_HEIGHT; r++) begin
            for (c = 0; c < camera_pkg::CROP_WIDTH; c++) begin
                if (r % 2 == 0 && c % 2 == 0) begin
                    red_sum = red_sum + pixel_value(seed, x0 + c, y0 + r);
                end else if (r % 2 == 1 && c % 2 == 1) begin
                    blue_sum = blue_sum + pixel_value(seed, x0 + c, y0 + r);
                end else begin
                    green_sum = green_sum + pixel_value(seed, x0 + c, y0 + r);
                end
            end
        end
        result.word = 32'd0;
        result.fields.red = (red_sum / 64) >> 2;
        result.fields.green = (green_sum / 128) >> 2;
        result.fields.blue = (blue_sum / 64) >> 2;
        return result;
    endfunction

    task automatic check_metering_for(input int seed, input int x0, input int y0);
        logic [31:0] data;
        wb_read(camera_pkg::REG_METERING, data);
        check_metering(data, expected_metering(seed, x0, y0), "METERING");
    endtask

    // byte i is column x0 + i mod 16, row y0 + i div 16, bits 9 to 2
    task automatic check_buffer(input int seed, input int x0, input int y0);
        logic [31:0] data;
        logic [9:0]  pixel;
        int          i;
        for (i = 0; i < camera_pkg::BUFFER_DEPTH; i++) begin
            wb_read(camera_pkg::BUFFER_BASE + 12'(4 * i), data);
            pixel = pixel_value(seed, x0 + i % camera_pkg::CROP_WIDTH,
                                y0 + i / camera_pkg::CROP_WIDTH);
            check_word(data, {24'd0, pixel[9:2]}, $sformatf("buffer byte %0d", i));
        end
    endtask

    task automatic test_reset_values();
        logic [31:0] data;
        wb_read(camera_pkg::REG_CROP_X, data);
        check_word(data, 32'd0, "CROP_X after reset");
        wb_read(camera_pkg::REG_CROP_Y, data);
        check_word(data, 32'd0, "CROP_Y after reset");
        wb_read(camera_pkg::REG_STATUS, data);
        check_word(data, 32'd0, "STATUS after reset");
        wb_read(camera_pkg::REG_METERING, data);
        check_word(data, 32'd0, "METERING after reset");
    endtask

    task automatic test_crop_readback();
        logic [31:0] data;
        wb_write(camera_pkg::REG_CROP_X, 32'd7);
        wb_write(camera_pkg::REG_CROP_Y, 32'd5);
        wb_read(camera_pkg::REG_CROP_X, data);
        check_word(data, 32'd6, "CROP_X after odd write");
        wb_read(camera_pkg::REG_CROP_Y, data);
        check_word(data, 32'd4, "CROP_Y after odd write");
    endtask

    task automatic test_capture(input int seed, input int x0, input int y0);
        logic [31:0] data;
        wb_write(camera_pkg::REG_CROP_X, x0);
        wb_write(camera_pkg::REG_CROP_Y, y0);
        wb_write(camera_pkg::REG_CONTROL, 32'd1);
        // arming clears done and the byte count
        wb_read(camera_pkg::REG_STATUS, data);
        check_word(data, 32'd0, "STATUS after capture request");
        send_frame(seed);
        wb_read(camera_pkg::REG_STATUS, data);
        check_word(data, status_done, "STATUS after capture");
        check_buffer(seed, x0, y0);
    endtask

    task automatic test_no_capture();
        logic [31:0] data;
        send_frame(seed_second);
        wb_read(camera_pkg::REG_STATUS, data);
        check_word(data, status_done, "STATUS after frame without capture");
        check_buffer(seed_first, 6, 4);
        check_metering_for(seed_second, 6, 4);
    endtask

    initial begin
        seed_first = $urandom(21) % 1024;
        mipi_byte_reset_n = 1'b0;
        bayer_data = '0;
        line_valid = 1'b0;
        frame_valid = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        status_done = (32'd1 << 16) | camera_pkg::BUFFER_DEPTH;
        seed_second = $urandom % 1024;
        if (seed_second == seed_first) begin
            seed_second = (seed_first + 1) % 1024;
        end
        seed_third = $urandom % 1024;
        // new window must not reproduce the old buffer contents
        if (pixel_value(seed_third, 20, 12) == pixel_value(seed_first, 6, 4)) begin
            seed_third = (seed_third + 1) % 1024;
        end
        repeat (2) @(posedge mipi_byte_clock);
        mipi_byte_reset_n <= 1'b1;

        test_reset_values();
        test_crop_readback();
        test_capture(seed_first, 6, 4);
        check_metering_for(seed_first, 6, 4);
        test_no_capture();
        // window moves between frames
        test_capture(seed_third, 20, 12);
        check_metering_for(seed_third, 20, 12);

        if (dut.protocol_checks.failure_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Protocol assertions reported %0d errors", dut.protocol_checks.failure_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- tb/camera_assertions.sv
/*
 * Protocol assertions bound to the camera top level:
 * Wishbone ack rules and cropped stream framing
 */
`timescale 1ns/1ns
`default_nettype none

module camera_assertions (
    input wire mipi_byte_clock,
    input wire mipi_byte_reset_n,
    input wire wb_cyc_i,
    input wire wb_stb_i,
    input wire wb_ack_i,
    input wire crop_line_valid_i,
    input wire crop_frame_valid_i
);

    int failure_count = 0;

    // ack only answers a live request
    ack_with_request: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else begin
        $error("wishbone ack without cyc and stb");
        failure_count = failure_count + 1;
    end

    single_cycle_ack: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        wb_ack_i |=> !wb_ack_i)
    else begin
        $error("wishbone ack held for two cycles");
        failure_count = failure_count + 1;
    end

    line_inside_frame: assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        crop_line_valid_i |-> crop_frame_valid_i)
    else begin
        $error("cropped line valid outside cropped frame valid");
        failure_count = failure_count + 1;
    end

endmodule

bind camera_top camera_assertions protocol_checks (
    .mipi_byte_clock(mipi_byte_clock),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_ack_i(wb_ack_o),
    .crop_line_valid_i(crop_line_valid),
    .crop_frame_valid_i(crop_frame_valid)
);

`default_nettype wire

//--- logic/camera_top.sv
/*
 * Camera front end top level: crop, metering, capture
 * buffer and Wishbone registers on the MIPI byte clock
 */
`timescale 1ns/1ns
`default_nettype none

module camera_top (
    input  wire                               mipi_byte_clock,
    input  wire                               mipi_byte_reset_n,
    input  wire [camera_pkg::PIXEL_WIDTH-1:0] bayer_data_i,
    input  wire                               line_valid_i,
    input  wire                               frame_valid_i,
    input  wire                               wb_cyc_i,
    input  wire                               wb_stb_i,
    input  wire                               wb_we_i,
    input  wire [11:0]                        wb_adr_i,
    input  wire [31:0]                        wb_dat_i,
    output logic [31:0]                       wb_dat_o,
    output logic                              wb_ack_o
);

    logic [camera_pkg::PIXEL_WIDTH-1:0]       crop_data;
    logic                                     crop_line_valid;
    logic                                     crop_frame_valid;
    logic [camera_pkg::COORD_WIDTH-1:0]       crop_x_start;
    logic [camera_pkg::COORD_WIDTH-1:0]       crop_y_start;
    logic                                     capture_start;
    logic [camera_pkg::BUFFER_ADDR_WIDTH-1:0] buffer_read_addr;
    logic [7:0]                               buffer_read_data;
    logic                                     capture_done;
    logic [8:0]                               bytes_captured;
    camera_pkg::metering_t                    metering_word;

    frame_crop frame_crop (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .bayer_data_i(bayer_data_i),
        .line_valid_i(line_valid_i),
        .frame_valid_i(frame_valid_i),
        .crop_x_start_i(crop_x_start),
        .crop_y_start_i(crop_y_start),
        .crop_data_o(crop_data),
        .crop_line_valid_o(crop_line_valid),
        .crop_frame_valid_o(crop_frame_valid)
    );

    bayer_metering bayer_metering (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .crop_data_i(crop_data),
        .crop_line_valid_i(crop_line_valid),
        .crop_frame_valid_i(crop_frame_valid),
        .metering_word_o(metering_word)
    );

    image_buffer image_buffer (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .crop_data_i(crop_data),
        .crop_line_valid_i(crop_line_valid),
        .crop_frame_valid_i(crop_frame_valid),
        .capture_start_i(capture_start),
        .buffer_read_addr_i(buffer_read_addr),
        .buffer_read_data_o(buffer_read_data),
        .capture_done_o(capture_done),
        .bytes_captured_o(bytes_captured)
    );

    camera_registers camera_registers (
        .mipi_byte_clock(mipi_byte_clock),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o),
        .metering_word_i(metering_word),
        .buffer_read_data_i(buffer_read_data),
        .capture_done_i(capture_done),
        .bytes_captured_i(bytes_captured),
        .crop_x_start_o(crop_x_start),
        .crop_y_start_o(crop_y_start),
        .capture_start_o(capture_start),
        .buffer_read_addr_o(buffer_read_addr)
    );

endmodule

`default_nettype wire

//--- logic/camera_registers.sv
/*
 * Wishbone classic slave: control, crop position, status,
 * metering and the buffer read window
 */
`timescale 1ns/1ns
`default_nettype none

module camera_registers (
    input  wire                                      mipi_byte_clock,
    input  wire                                      mipi_byte_reset_n,
    input  wire                                      wb_cyc_i,
    input  wire                                      wb_stb_i,
    input  wire                                      wb_we_i,
    input  wire  [11:0]                              wb_adr_i,
    input  wire  [31:0]                              wb_dat_i,
    output logic [31:0]                              wb_dat_o,
    output logic                                     wb_ack_o,
    input  wire  camera_pkg::metering_t              metering_word_i,
    input  wire  [7:0]                               buffer_read_data_i,
    input  wire                                      capture_done_i,
    input  wire  [8:0]                               bytes_captured_i,
    output logic [camera_pkg::COORD_WIDTH-1:0]       crop_x_start_o,
    output logic [camera_pkg::COORD_WIDTH-1:0]       crop_y_start_o,
    output logic                                     capture_start_o,
    output logic [camera_pkg::BUFFER_ADDR_WIDTH-1:0] buffer_read_addr_o
);

    logic request;
    logic write_request;
    logic buffer_hit;

    // first cycle of an access, ack not yet given
    assign request = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign write_request = request && wb_we_i;

    // 0x400 to 0x7fc
    assign buffer_hit = (wb_adr_i[11:10] == camera_pkg::BUFFER_BASE[11:10]);

    // word address into the buffer, memory answers in the ack cycle
    assign buffer_read_addr_o = wb_adr_i[camera_pkg::BUFFER_ADDR_WIDTH+1:2];

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            wb_ack_o <= 1'b0;
            capture_start_o <= 1'b0;
            crop_x_start_o <= '0;
            crop_y_start_o <= '0;
        end else begin
            wb_ack_o <= request;
            capture_start_o <= 1'b0;
            if (write_request) begin
                case (wb_adr_i)
                    camera_pkg::REG_CONTROL: begin
                        capture_start_o <= wb_dat_i[0];
                    end
                    // bit 0 dropped, window stays on an RGGB boundary
                    camera_pkg::REG_CROP_X: begin
                        crop_x_start_o <= {wb_dat_i[camera_pkg::COORD_WIDTH-1:1], 1'b0};
                    end
                    camera_pkg::REG_CROP_Y: begin
                        crop_y_start_o <= {wb_dat_i[camera_pkg::COORD_WIDTH-1:1], 1'b0};
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // address held by the master, so the mux is valid during ack
    always_comb begin
        wb_dat_o = 32'd0;
        if (buffer_hit) begin
            wb_dat_o = {24'd0, buffer_read_data_i};
        end else begin
            case (wb_adr_i)
                camera_pkg::REG_CROP_X: begin
                    wb_dat_o = {{(32 - camera_pkg::COORD_WIDTH){1'b0}}, crop_x_start_o};
                end
                camera_pkg::REG_CROP_Y: begin
                    wb_dat_o = {{(32 - camera_pkg::COORD_WIDTH){1'b0}}, crop_y_start_o};
                end
                camera_pkg::REG_STATUS: begin
                    wb_dat_o = {15'd0, capture_done_i, 7'd0, bytes_captured_i};
                end
                camera_pkg::REG_METERING: begin
                    wb_dat_o = metering_word_i.word;
                end
                default: begin
                    wb_dat_o = 32'd0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/image_buffer.sv
/*
 * Capture buffer: armed by a capture request, stores the next
 * cropped frame as 8-bit pixels in a 256-byte memory with a
 * synchronous read port, reports done and the byte count
 */
`timescale 1ns/1ns
`default_nettype none

module image_buffer (
    input  wire                                      mipi_byte_clock,
    input  wire                                      mipi_byte_reset_n,
    input  wire  [camera_pkg::PIXEL_WIDTH-1:0]       crop_data_i,
    input  wire                                      crop_line_valid_i,
    input  wire                                      crop_frame_valid_i,
    input  wire                                      capture_start_i,
    input  wire  [camera_pkg::BUFFER_ADDR_WIDTH-1:0] buffer_read_addr_i,
    output logic [7:0]                               buffer_read_data_o,
    output logic                                     capture_done_o,
    output logic [8:0]                               bytes_captured_o
);

    logic [7:0] memory [camera_pkg::BUFFER_DEPTH];
    logic       armed_q;
    logic       writing_q;
    logic       frame_valid_q;
    logic       write_start;
    logic       write_enable;

    assign write_start = armed_q && !writing_q && crop_frame_valid_i && !frame_valid_q;
    assign write_enable = crop_line_valid_i && (writing_q || write_start) &&
                          (bytes_captured_o < camera_pkg::BUFFER_DEPTH);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            armed_q <= 1'b0;
            writing_q <= 1'b0;
            frame_valid_q <= 1'b0;
            capture_done_o <= 1'b0;
            bytes_captured_o <= '0;
        end else begin
            frame_valid_q <= crop_frame_valid_i;
            if (capture_start_i) begin
                armed_q <= 1'b1;
                writing_q <= 1'b0;
                capture_done_o <= 1'b0;
                bytes_captured_o <= '0;
            end else begin
                if (write_start) begin
                    writing_q <= 1'b1;
                end
                if (write_enable) begin
                    bytes_captured_o <= bytes_captured_o + 1'b1;
                end
                // frame over, image complete
                if (writing_q && !crop_frame_valid_i) begin
                    writing_q <= 1'b0;
                    armed_q <= 1'b0;
                    capture_done_o <= 1'b1;
                end
            end
        end
    end

    // top 8 bits of each pixel
    always_ff @(posedge mipi_byte_clock) begin
        if (write_enable && !capture_start_i) begin
            memory[bytes_captured_o[camera_pkg::BUFFER_ADDR_WIDTH-1:0]] <=
                crop_data_i[camera_pkg::PIXEL_WIDTH-1 -: 8];
        end
        buffer_read_data_o <= memory[buffer_read_addr_i];
    end

endmodule

`default_nettype wire

//--- logic/bayer_metering.sv
/*
 * Metering stage: sums red, green and blue over the cropped
 * RGGB window and publishes 8-bit averages at frame end
 */
`timescale 1ns/1ns
`default_nettype none

module bayer_metering (
    input  wire                               mipi_byte_clock,
    input  wire                               mipi_byte_reset_n,
    input  wire [camera_pkg::PIXEL_WIDTH-1:0] crop_data_i,
    input  wire                               crop_line_valid_i,
    input  wire                               crop_frame_valid_i,
    output camera_pkg::metering_t             metering_word_o
);

    // 64 red, 128 green and 64 blue pixels per window
    logic [camera_pkg::PIXEL_WIDTH+5:0] red_sum;
    logic [camera_pkg::PIXEL_WIDTH+6:0] green_sum;
    logic [camera_pkg::PIXEL_WIDTH+5:0] blue_sum;
    logic                               col_odd_q;
    logic                               row_odd_q;
    logic                               line_valid_q;
    logic                               frame_valid_q;
    logic                               frame_start;
    logic                               frame_end;

    assign frame_start = crop_frame_valid_i && !frame_valid_q;
    assign frame_end = frame_valid_q && !crop_frame_valid_i;

    // bayer phase within the cropped window
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            col_odd_q <= 1'b0;
            row_odd_q <= 1'b0;
            line_valid_q <= 1'b0;
            frame_valid_q <= 1'b0;
        end else begin
            line_valid_q <= crop_line_valid_i;
            frame_valid_q <= crop_frame_valid_i;
            if (crop_line_valid_i) begin
                col_odd_q <= !col_odd_q;
            end else begin
                col_odd_q <= 1'b0;
            end
            if (frame_start) begin
                row_odd_q <= 1'b0;
            end else if (line_valid_q && !crop_line_valid_i) begin
                row_odd_q <= !row_odd_q;
            end
        end
    end

    // even row even column is red, odd row odd column is blue
    always_ff @(posedge mipi_byte_clock) begin
        if (frame_start) begin
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
        end else if (crop_line_valid_i) begin
            if (!row_odd_q && !col_odd_q) begin
                red_sum <= red_sum + crop_data_i;
            end else if (row_odd_q && col_odd_q) begin
                blue_sum <= blue_sum + crop_data_i;
            end else begin
                green_sum <= green_sum + crop_data_i;
            end
        end
    end

    // divide by count, then keep the top 8 of 10 bits
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            metering_word_o.word <= '0;
        end else if (frame_end) begin
            metering_word_o.fields.unused <= 8'd0;
            metering_word_o.fields.red <= red_sum[camera_pkg::PIXEL_WIDTH+5 -: 8];
            metering_word_o.fields.green <= green_sum[camera_pkg::PIXEL_WIDTH+6 -: 8];
            metering_word_o.fields.blue <= blue_sum[camera_pkg::PIXEL_WIDTH+5 -: 8];
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_crop.sv
/*
 * Crop stage: counts raw column and row, latches the window
 * start at frame start and passes on the 16 by 16 window
 * one cycle after the raw input
 */
`timescale 1ns/1ns
`default_nettype none

module frame_crop (
    input  wire                                mipi_byte_clock,
    input  wire                                mipi_byte_reset_n,
    input  wire  [camera_pkg::PIXEL_WIDTH-1:0] bayer_data_i,
    input  wire                                line_valid_i,
    input  wire                                frame_valid_i,
    input  wire  [camera_pkg::COORD_WIDTH-1:0] crop_x_start_i,
    input  wire  [camera_pkg::COORD_WIDTH-1:0] crop_y_start_i,
    output logic [camera_pkg::PIXEL_WIDTH-1:0] crop_data_o,
    output logic                               crop_line_valid_o,
    output logic                               crop_frame_valid_o
);

    logic [camera_pkg::COORD_WIDTH-1:0] col_q;
    logic [camera_pkg::COORD_WIDTH-1:0] row_q;
    logic [camera_pkg::COORD_WIDTH-1:0] x_start_q;
    logic [camera_pkg::COORD_WIDTH-1:0] y_start_q;
    logic [camera_pkg::COORD_WIDTH-1:0] col_offset;
    logic [camera_pkg::COORD_WIDTH-1:0] row_offset;
    logic                               line_valid_q;
    logic                               in_window;

    assign col_offset = col_q - x_start_q;
    assign row_offset = row_q - y_start_q;

    // offsets only meaningful once past the start
    assign in_window = (col_q >= x_start_q) && (col_offset < camera_pkg::CROP_WIDTH) &&
                       (row_q >= y_start_q) && (row_offset < camera_pkg::CROP_HEIGHT);

    // raw coordinates of the current input pixel
    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            col_q <= '0;
            row_q <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;
            if (line_valid_i) begin
                col_q <= col_q + 1'b1;
            end else begin
                col_q <= '0;
            end
            // next row after each line ends
            if (!frame_valid_i) begin
                row_q <= '0;
            end else if (line_valid_q && !line_valid_i) begin
                row_q <= row_q + 1'b1;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_start_q <= '0;
            y_start_q <= '0;
            crop_line_valid_o <= 1'b0;
            crop_frame_valid_o <= 1'b0;
        end else begin
            crop_frame_valid_o <= frame_valid_i;
            crop_line_valid_o <= frame_valid_i && line_valid_i && in_window;
            // window moves only between frames
            if (frame_valid_i && !crop_frame_valid_o) begin
                x_start_q <= crop_x_start_i;
                y_start_q <= crop_y_start_i;
            end
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        crop_data_o <= bayer_data_i;
    end

endmodule

`default_nettype wire

//--- logic/camera_pkg.sv
/*
 * Shared definitions for the camera front end:
 * pixel and coordinate widths, crop window and buffer sizes,
 * the Wishbone register map and the metering word union
 */
`default_nettype none

package camera_pkg;

    // raw bayer stream
    localparam int PIXEL_WIDTH = 10;
    localparam int COORD_WIDTH = 11;

    // cropped window
    localparam int CROP_WIDTH = 16;
    localparam int CROP_HEIGHT = 16;

    // one byte per cropped pixel
    localparam int BUFFER_DEPTH = CROP_WIDTH * CROP_HEIGHT;
    localparam int BUFFER_ADDR_WIDTH = 8;

    // register byte offsets
    localparam logic [11:0] REG_CONTROL = 12'h000;
    localparam logic [11:0] REG_CROP_X = 12'h004;
    localparam logic [11:0] REG_CROP_Y = 12'h008;
    localparam logic [11:0] REG_STATUS = 12'h00C;
    localparam logic [11:0] REG_METERING = 12'h010;

    // buffer byte i sits at BUFFER_BASE + 4 * i
    localparam logic [11:0] BUFFER_BASE = 12'h400;

    // metering writes the fields, the bus reads the word
    typedef union packed {
        struct packed {
            logic [7:0] unused;
            logic [7:0] red;
            logic [7:0] green;
            logic [7:0] blue;
        } fields;
        logic [31:0] word;
    } metering_t;

endpackage

`default_nettype wire
